//--- hw/rvc_pkg.sv
package rvc_pkg;

    // Multiply extension level
    typedef enum logic [1:0] {
        MUL_OFF,
        MUL_ZMMUL,
        MUL_M
    } mul_e;

    // Fetch aligner states
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        ACCESS,
        HOLD
    } fetch_state_e;

    // RV32 major opcodes
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

endpackage

//--- hw/decompresser.sv
`timescale 1ns/1ps

module decompresser
    import rvc_pkg::*;
#(
    parameter mul_e MULEXT    = MUL_M,
    parameter bit   ZCBEnable = 1'b0
) (
    input  logic [15:0] instruction_i,
    output logic [31:0] instruction_o
);

    logic [15:0] ins;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rd_p;
    logic [4:0]  rs1_p;
    logic [5:0]  imm_ci;
    logic [11:0] imm_4spn;
    logic [11:0] imm_lw;
    logic [11:0] imm_lwsp;
    logic [11:0] imm_swsp;
    logic [11:0] imm_16sp;
    logic [19:0] imm_j;
    logic [6:0]  br_hi;
    logic [4:0]  br_lo;
    logic [6:0]  alu_f7;
    logic [2:0]  alu_f3;
    logic [31:0] exp_q0;
    logic [31:0] exp_q1;
    logic [31:0] exp_q2;

    assign ins    = instruction_i;
    assign funct3 = ins[15:13];
    assign rd     = ins[11:7];
    assign rs2    = ins[6:2];
    // Compressed register fields map onto x8..x15
    assign rd_p   = {2'b01, ins[4:2]};
    assign rs1_p  = {2'b01, ins[9:7]};
    assign imm_ci = {ins[12], ins[6:2]};

    // Immediates rebuilt in 32-bit field order
    assign imm_4spn = {2'b00, ins[10:7], ins[12:11], ins[5], ins[6], 2'b00};
    assign imm_lw   = {5'b00000, ins[5], ins[12:10], ins[6], 2'b00};
    assign imm_lwsp = {4'b0000, ins[3:2], ins[12], ins[6:4], 2'b00};
    assign imm_swsp = {4'b0000, ins[8:7], ins[12:9], 2'b00};
    assign imm_16sp = {{3{ins[12]}}, ins[4:3], ins[5], ins[2], ins[6], 4'b0000};
    assign imm_j    = {ins[12], ins[8], ins[10:9], ins[6], ins[7], ins[2], ins[11],
                       ins[5:3], ins[12], {8{ins[12]}}};
    assign br_hi    = {{4{ins[12]}}, ins[6:5], ins[2]};
    assign br_lo    = {ins[11:10], ins[4:3], ins[12]};

    // C.SUB, C.XOR, C.OR, C.AND share one format
    always_comb begin
        alu_f7 = 7'b0000000;
        case (ins[6:5])
            2'b00: begin
                alu_f7 = 7'b0100000;
                alu_f3 = 3'b000;
            end
            2'b01:   alu_f3 = 3'b100;
            2'b10:   alu_f3 = 3'b110;
            default: alu_f3 = 3'b111;
        endcase
    end

    // Quadrant 0
    always_comb begin
        exp_q0 = '0;
        case (funct3)
            3'b000: exp_q0 = (imm_4spn != '0) ? {imm_4spn, 5'd2, 3'b000, rd_p, OP_IMM} : '0;
            3'b010: exp_q0 = {imm_lw, rs1_p, 3'b010, rd_p, LOAD};
            3'b110: exp_q0 = {imm_lw[11:5], rd_p, rs1_p, 3'b010, imm_lw[4:0], STORE};
            3'b100: begin
                if (ZCBEnable) begin
                    case (ins[12:10])
                        // C.LBU
                        3'b000: exp_q0 = {10'b0, ins[5], ins[6], rs1_p, 3'b100, rd_p, LOAD};
                        // C.LHU and C.LH, picked by bit 6
                        3'b001: exp_q0 = {10'b0, ins[5], 1'b0, rs1_p,
                                          (ins[6] ? 3'b001 : 3'b101), rd_p, LOAD};
                        3'b010: exp_q0 = {7'b0, rd_p, rs1_p, 3'b000, 3'b000, ins[5], ins[6], STORE};
                        3'b011: exp_q0 = {7'b0, rd_p, rs1_p, 3'b001, 3'b000, ins[5], 1'b0, STORE};
                        default: exp_q0 = '0;
                    endcase
                end
            end
            default: exp_q0 = '0;
        endcase
    end

    // Quadrant 1
    always_comb begin
        exp_q1 = '0;
        case (funct3)
            3'b000: exp_q1 = {{6{imm_ci[5]}}, imm_ci, rd, 3'b000, rd, OP_IMM};
            // C.JAL links to x1, C.J to x0
            3'b001, 3'b101: exp_q1 = {imm_j, 4'b0000, ~ins[15], JAL};
            3'b010: exp_q1 = {{6{imm_ci[5]}}, imm_ci, 5'd0, 3'b000, rd, OP_IMM};
            3'b011: begin
                if (imm_ci != '0) begin
                    exp_q1 = (rd == 5'd2) ? {imm_16sp, rd, 3'b000, rd, OP_IMM}
                                          : {{14{imm_ci[5]}}, imm_ci, rd, LUI};
                end
            end
            3'b100: begin
                case (ins[11:10])
                    2'b00: exp_q1 = {7'b0000000, ins[6:2], rs1_p, 3'b101, rs1_p, OP_IMM};
                    2'b01: exp_q1 = {7'b0100000, ins[6:2], rs1_p, 3'b101, rs1_p, OP_IMM};
                    2'b10: exp_q1 = {{6{imm_ci[5]}}, imm_ci, rs1_p, 3'b111, rs1_p, OP_IMM};
                    default: begin
                        if (!ins[12]) begin
                            exp_q1 = {alu_f7, rd_p, rs1_p, alu_f3, rs1_p, OP};
                        end else if (ins[6:5] == 2'b10 && MULEXT != MUL_OFF) begin
                            exp_q1 = {7'b0000001, rd_p, rs1_p, 3'b000, rs1_p, OP};
                        end else if (ins[6:5] == 2'b11 && ZCBEnable) begin
                            // C.ZEXT.B as andi 0xff, C.NOT as xori -1
                            if (ins[4:2] == 3'b000) begin
                                exp_q1 = {12'h0ff, rs1_p, 3'b111, rs1_p, OP_IMM};
                            end else if (ins[4:2] == 3'b101) begin
                                exp_q1 = {12'hfff, rs1_p, 3'b100, rs1_p, OP_IMM};
                            end
                        end
                    end
                endcase
            end
            3'b110: exp_q1 = {br_hi, 5'd0, rs1_p, 3'b000, br_lo, BRANCH};
            default: exp_q1 = {br_hi, 5'd0, rs1_p, 3'b001, br_lo, BRANCH};
        endcase
    end

    // Quadrant 2
    always_comb begin
        exp_q2 = '0;
        case (funct3)
            3'b000: exp_q2 = {7'b0, ins[6:2], rd, 3'b001, rd, OP_IMM};
            3'b010: exp_q2 = (rd != '0) ? {imm_lwsp, 5'd2, 3'b010, rd, LOAD} : '0;
            3'b100: begin
                if (!ins[12]) begin
                    if (rs2 != '0) begin
                        exp_q2 = {7'b0, rs2, 5'd0, 3'b000, rd, OP};
                    end else if (rd != '0) begin
                        exp_q2 = {12'b0, rd, 3'b000, 5'd0, JALR};
                    end
                end else begin
                    if (rs2 != '0) begin
                        exp_q2 = {7'b0, rs2, rd, 3'b000, rd, OP};
                    end else if (rd != '0) begin
                        exp_q2 = {12'b0, rd, 3'b000, 5'd1, JALR};
                    end else begin
                        exp_q2 = {12'd1, 5'd0, 3'b000, 5'd0, SYSTEM};
                    end
                end
            end
            3'b110: exp_q2 = {imm_swsp[11:5], rs2, 5'd2, 3'b010, imm_swsp[4:0], STORE};
            default: exp_q2 = '0;
        endcase
    end

    always_comb begin
        case (ins[1:0])
            2'b00:   instruction_o = exp_q0;
            2'b01:   instruction_o = exp_q1;
            2'b10:   instruction_o = exp_q2;
            default: instruction_o = '0;
        endcase
    end

endmodule

//--- hw/fetch_aligner.sv
`timescale 1ns/1ps

module fetch_aligner
    import rvc_pkg::*;
#(
    parameter int AW = 12
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          start_i,
    input  logic [31:0]   start_pc_i,
    output logic          psel_o,
    output logic          penable_o,
    output logic [AW-1:0] paddr_o,
    input  logic [31:0]   prdata_i,
    input  logic          pready_i,
    output logic [15:0]   half_o,
    input  logic [31:0]   expanded_i,
    output logic          instr_valid_o,
    input  logic          instr_ready_i,
    output logic [31:0]   instr_o,
    output logic [31:0]   instr_pc_o,
    output logic          instr_compressed_o
);

    // Any base opcode ends in 2'b11
    localparam logic [6:0] FULL_OP = OP;

    fetch_state_e  state_q;
    logic [31:0]   pc_q;
    logic [31:0]   word_q;
    logic [AW-3:0] word_addr_q;
    logic          word_vld_q;
    logic [15:0]   carry_q;
    logic          carry_vld_q;
    logic [AW-1:0] paddr_q;

    logic [AW-3:0] pc_word;
    logic [AW-3:0] next_word;
    logic          have_cur;
    logic          have_next;
    logic [15:0]   low_half;
    logic          is_full;
    logic          straddle;
    logic          avail;
    logic          start_ok;
    logic          issue;
    logic          capture;

    assign pc_word   = pc_q[AW-1:2];
    assign next_word = pc_word + 1'b1;
    assign have_cur  = word_vld_q && (word_addr_q == pc_word);
    assign have_next = word_vld_q && (word_addr_q == next_word);
    assign low_half  = carry_vld_q ? carry_q : (pc_q[1] ? word_q[31:16] : word_q[15:0]);
    assign is_full   = (low_half[1:0] == FULL_OP[1:0]);
    // 32-bit instruction starting in the upper half of the buffered word
    assign straddle  = !carry_vld_q && have_cur && is_full && pc_q[1];
    assign avail     = carry_vld_q ? have_next : (have_cur && !straddle);

    assign start_ok = start_i && (state_q == IDLE || state_q == HOLD);
    assign issue    = (state_q == HOLD) && !avail && !start_ok;
    assign capture  = (state_q == ACCESS) && pready_i;

    assign psel_o    = (state_q == REQ) || (state_q == ACCESS);
    assign penable_o = (state_q == ACCESS);
    assign paddr_o   = paddr_q;

    assign half_o             = low_half;
    assign instr_valid_o      = (state_q == HOLD) && avail;
    assign instr_compressed_o = !is_full;
    assign instr_pc_o         = pc_q;
    assign instr_o            = !is_full    ? expanded_i :
                                carry_vld_q ? {word_q[15:0], carry_q} : word_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            pc_q        <= '0;
            word_vld_q  <= 1'b0;
            carry_vld_q <= 1'b0;
        end else if (start_ok) begin
            state_q     <= HOLD;
            pc_q        <= start_pc_i;
            word_vld_q  <= 1'b0;
            carry_vld_q <= 1'b0;
        end else begin
            case (state_q)
                REQ: state_q <= ACCESS;
                ACCESS: begin
                    if (pready_i) begin
                        word_vld_q <= 1'b1;
                        state_q    <= HOLD;
                    end
                end
                HOLD: begin
                    if (avail && instr_ready_i) begin
                        pc_q        <= pc_q + (is_full ? 32'd4 : 32'd2);
                        carry_vld_q <= 1'b0;
                    end else if (!avail) begin
                        carry_vld_q <= carry_vld_q || straddle;
                        state_q     <= REQ;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            word_q      <= prdata_i;
            word_addr_q <= paddr_q[AW-1:2];
        end
        if (issue) begin
            paddr_q <= {((straddle || carry_vld_q) ? next_word : pc_word), 2'b00};
            if (straddle) begin
                carry_q <= word_q[31:16];
            end
        end
    end

    // Access phase only after a setup cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        penable_o |-> psel_o && $past(psel_o));

    // Held instruction survives back-pressure unchanged
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_o && !instr_ready_i && !start_i |=>
            instr_valid_o && $stable(instr_o) && $stable(instr_pc_o));

endmodule

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
    parameter int AW = 12
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          ld_psel_i,
    input  logic          ld_penable_i,
    input  logic          ld_pwrite_i,
    input  logic [AW-1:0] ld_paddr_i,
    input  logic [31:0]   ld_pwdata_i,
    output logic [31:0]   ld_prdata_o,
    output logic          ld_pready_o,
    input  logic          f_psel_i,
    input  logic          f_penable_i,
    input  logic [AW-1:0] f_paddr_i,
    output logic [31:0]   f_prdata_o,
    output logic          f_pready_o,
    output logic          m_psel_o,
    output logic          m_penable_o,
    output logic          m_pwrite_o,
    output logic [AW-1:0] m_paddr_o,
    output logic [31:0]   m_pwdata_o,
    input  logic [31:0]   m_prdata_i,
    input  logic          m_pready_i
);

    logic owner_vld_q;
    logic owner_ld_q;
    logic gnt_ld;
    logic gnt_f;

    // Loader wins a tie at setup, owner is kept until access ends
    assign gnt_ld = owner_vld_q ? owner_ld_q : ld_psel_i;
    assign gnt_f  = owner_vld_q ? !owner_ld_q : (f_psel_i && !ld_psel_i);

    assign m_psel_o    = (gnt_ld && ld_psel_i) || (gnt_f && f_psel_i);
    // First granted cycle is always a setup cycle for the memory
    assign m_penable_o = owner_vld_q && (owner_ld_q ? ld_penable_i : f_penable_i);
    assign m_pwrite_o  = gnt_ld && ld_pwrite_i;
    assign m_paddr_o   = gnt_ld ? ld_paddr_i : f_paddr_i;
    assign m_pwdata_o  = ld_pwdata_i;

    assign ld_prdata_o = gnt_ld ? m_prdata_i : '0;
    assign ld_pready_o = gnt_ld && m_pready_i;
    assign f_prdata_o  = gnt_f ? m_prdata_i : '0;
    assign f_pready_o  = gnt_f && m_pready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_vld_q <= 1'b0;
            owner_ld_q  <= 1'b0;
        end else if (!owner_vld_q) begin
            owner_vld_q <= m_psel_o;
            owner_ld_q  <= gnt_ld;
        end else if (m_penable_o && m_pready_i) begin
            owner_vld_q <= 1'b0;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(gnt_ld && gnt_f));

endmodule

//--- hw/instr_mem.sv
`timescale 1ns/1ps

module instr_mem #(
    parameter int MEM_WORDS = 256,
    parameter int AW        = 10
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          psel_i,
    input  logic          penable_i,
    input  logic          pwrite_i,
    input  logic [AW-1:0] paddr_i,
    input  logic [31:0]   pwdata_i,
    output logic [31:0]   prdata_o,
    output logic          pready_o
);

    logic [31:0]   mem_q [MEM_WORDS];
    logic [AW-3:0] word_addr;

    assign word_addr = paddr_i[AW-1:2];

    always_ff @(posedge clk_i) begin
        if (psel_i && penable_i && pwrite_i) begin
            mem_q[word_addr] <= pwdata_i;
        end
    end

    // No wait states
    assign pready_o = psel_i && penable_i;
    assign prdata_o = mem_q[word_addr];

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_i |-> (32'(word_addr) < MEM_WORDS));

endmodule

//--- hw/rvc_fetch_top.sv
`timescale 1ns/1ps

module rvc_fetch_top
    import rvc_pkg::*;
#(
    parameter mul_e MULEXT    = MUL_M,
    parameter bit   ZCBEnable = 1'b1,
    parameter int   MEM_WORDS = 256,
    localparam int  AW        = $clog2(MEM_WORDS) + 2
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          ld_psel_i,
    input  logic          ld_penable_i,
    input  logic          ld_pwrite_i,
    input  logic [AW-1:0] ld_paddr_i,
    input  logic [31:0]   ld_pwdata_i,
    output logic [31:0]   ld_prdata_o,
    output logic          ld_pready_o,
    input  logic          start_i,
    input  logic [31:0]   start_pc_i,
    output logic          instr_valid_o,
    input  logic          instr_ready_i,
    output logic [31:0]   instr_o,
    output logic [31:0]   instr_pc_o,
    output logic          instr_compressed_o
);

    logic          f_psel;
    logic          f_penable;
    logic [AW-1:0] f_paddr;
    logic [31:0]   f_prdata;
    logic          f_pready;
    logic          m_psel;
    logic          m_penable;
    logic          m_pwrite;
    logic [AW-1:0] m_paddr;
    logic [31:0]   m_pwdata;
    logic [31:0]   m_prdata;
    logic          m_pready;
    logic [15:0]   half;
    logic [31:0]   expanded;

    instr_mem #(
        .MEM_WORDS (MEM_WORDS),
        .AW        (AW)
    ) mem_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (m_psel),
        .penable_i (m_penable),
        .pwrite_i  (m_pwrite),
        .paddr_i   (m_paddr),
        .pwdata_i  (m_pwdata),
        .prdata_o  (m_prdata),
        .pready_o  (m_pready)
    );

    bus_arbiter #(
        .AW (AW)
    ) arb_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ld_psel_i    (ld_psel_i),
        .ld_penable_i (ld_penable_i),
        .ld_pwrite_i  (ld_pwrite_i),
        .ld_paddr_i   (ld_paddr_i),
        .ld_pwdata_i  (ld_pwdata_i),
        .ld_prdata_o  (ld_prdata_o),
        .ld_pready_o  (ld_pready_o),
        .f_psel_i     (f_psel),
        .f_penable_i  (f_penable),
        .f_paddr_i    (f_paddr),
        .f_prdata_o   (f_prdata),
        .f_pready_o   (f_pready),
        .m_psel_o     (m_psel),
        .m_penable_o  (m_penable),
        .m_pwrite_o   (m_pwrite),
        .m_paddr_o    (m_paddr),
        .m_pwdata_o   (m_pwdata),
        .m_prdata_i   (m_prdata),
        .m_pready_i   (m_pready)
    );

    fetch_aligner #(
        .AW (AW)
    ) align_i (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .start_i            (start_i),
        .start_pc_i         (start_pc_i),
        .psel_o             (f_psel),
        .penable_o          (f_penable),
        .paddr_o            (f_paddr),
        .prdata_i           (f_prdata),
        .pready_i           (f_pready),
        .half_o             (half),
        .expanded_i         (expanded),
        .instr_valid_o      (instr_valid_o),
        .instr_ready_i      (instr_ready_i),
        .instr_o            (instr_o),
        .instr_pc_o         (instr_pc_o),
        .instr_compressed_o (instr_compressed_o)
    );

    decompresser #(
        .MULEXT    (MULEXT),
        .ZCBEnable (ZCBEnable)
    ) decomp_i (
        .instruction_i (half),
        .instruction_o (expanded)
    );

endmodule

//--- dv/tb_rvc_fetch.sv
`timescale 1ns/1ps

module tb_rvc_fetch
    import rvc_pkg::*;
();

    localparam int          AW   = 10;
    localparam logic [31:0] SEED = 32'h9e0a_058b;

    logic          clk_i;
    logic          rst_n_i;
    logic          ld_psel_i;
    logic          ld_penable_i;
    logic          ld_pwrite_i;
    logic [AW-1:0] ld_paddr_i;
    logic [31:0]   ld_pwdata_i;
    logic [31:0]   ld_prdata_o;
    logic          ld_pready_o;
    logic          start_i;
    logic [31:0]   start_pc_i;
    logic          instr_valid_o;
    logic          instr_ready_i;
    logic [31:0]   instr_o;
    logic [31:0]   instr_pc_o;
    logic          instr_compressed_o;

    // Header, program words, then instr/PC/flag triples
    logic [31:0] tv [0:127];
    int          n_words;
    int          n_rec;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;

    rvc_fetch_top #(.MULEXT(MUL_M), .ZCBEnable(1'b1), .MEM_WORDS(256)) dut_i (.*);

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with the stream incomplete, %0d errors so far",
                     cycles, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h at %0t",
                     name, expected, actual, $time);
            errors++;
        end
    endtask

    // One loader transfer, waits in the access phase until pready
    task automatic apb_transfer(input logic write, input logic [AW-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk_i);
        ld_psel_i    <= 1'b1;
        ld_penable_i <= 1'b0;
        ld_pwrite_i  <= write;
        ld_paddr_i   <= addr;
        ld_pwdata_i  <= wdata;
        @(posedge clk_i);
        ld_penable_i <= 1'b1;
        @(negedge clk_i);
        while (!ld_pready_o) begin
            @(negedge clk_i);
        end
        rdata = ld_prdata_o;
        @(posedge clk_i);
        ld_psel_i    <= 1'b0;
        ld_penable_i <= 1'b0;
        ld_pwrite_i  <= 1'b0;
    endtask

    task automatic reread_program();
        logic [31:0] rdata;
        for (int i = 0; i < n_words; i++) begin
            apb_transfer(1'b0, AW'(i * 4), 32'h0, rdata);
            check_value("ld_prdata_o", tv[3 + i], rdata);
        end
    endtask

    // Random ready, held outputs must not move while stalled
    task automatic consume_stream();
        logic [31:0] held_instr;
        logic [31:0] held_pc;
        logic        held_c;
        logic        held;
        int          got;
        int          base;
        held = 1'b0;
        got  = 0;
        while (got < n_rec) begin
            @(negedge clk_i);
            if (held) begin
                check_value("instr_valid_o", 32'h1, 32'(instr_valid_o));
                check_value("instr_o", held_instr, instr_o);
                check_value("instr_pc_o", held_pc, instr_pc_o);
                check_value("instr_compressed_o", 32'(held_c), 32'(instr_compressed_o));
            end
            held       = instr_valid_o && !instr_ready_i;
            held_instr = instr_o;
            held_pc    = instr_pc_o;
            held_c     = instr_compressed_o;
            if (instr_valid_o && instr_ready_i) begin
                base = 3 + n_words + 3 * got;
                check_value("instr_o", tv[base], instr_o);
                check_value("instr_pc_o", tv[base + 1], instr_pc_o);
                check_value("instr_compressed_o", tv[base + 2], 32'(instr_compressed_o));
                got++;
            end
            @(posedge clk_i);
            instr_ready_i <= (got < n_rec) && (($urandom % 4) != 0);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        ld_psel_i     = 1'b0;
        ld_penable_i  = 1'b0;
        ld_pwrite_i   = 1'b0;
        ld_paddr_i    = '0;
        ld_pwdata_i   = '0;
        start_i       = 1'b0;
        start_pc_i    = '0;
        instr_ready_i = 1'b0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        void'($urandom(SEED));
        $readmemh("dv/fetch_tests.txt", tv);
        n_words     = int'(tv[0]);
        n_rec       = int'(tv[2]);
        cycle_limit = 200 * n_rec + 8 * n_words + 40;

        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value("instr_valid_o", 32'h0, 32'(instr_valid_o));
        check_value("ld_pready_o", 32'h0, 32'(ld_pready_o));

        for (int i = 0; i < n_words; i++) begin
            apb_transfer(1'b1, AW'(i * 4), tv[3 + i], rdata);
        end
        reread_program();

        @(posedge clk_i);
        start_i    <= 1'b1;
        start_pc_i <= tv[1];
        @(posedge clk_i);
        start_i <= 1'b0;
        // Loader reads compete with the running fetch
        fork
            consume_stream();
            reread_program();
        join

        $display("Run finished with %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
hw/rvc_pkg.sv
hw/decompresser.sv
hw/fetch_aligner.sv
hw/bus_arbiter.sv
hw/instr_mem.sv
hw/rvc_fetch_top.sv
dv/tb_rvc_fetch.sv

//--- Makefile
TOP = tb_rvc_fetch

.PHONY: all compile run clean

all: run

compile: obj_dir/$(TOP)

obj_dir/$(TOP): all.f hw/*.sv dv/tb_rvc_fetch.sv
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o $(TOP)

# Echo the output and fail unless the pass line shows up
run: compile
	./obj_dir/$(TOP) | awk '{ print } /^TEST OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- dv/fetch_tests.txt
// Header: program word count, start PC, record count, then the program words
// Records: expected instr_o, instr_pc_o, instr_compressed_o
00000010 00000002 0000001a
08000001 88c84044 157d9c45 003100b3 52b74595 9c751234 8c059ce1 03138636
040e7ff0 80824722 c4019002 a0096785 40020000 80022000 00112623 00010001
01010413 00000002 1   00442483 00000004 1   00a480a3 00000006 1
02940433 00000008 1   fff50513 0000000a 1   003100b3 0000000c 0
00500593 00000010 1   123452b7 00000012 0   fff44413 00000016 1
0ff4f493 00000018 1   40940433 0000001a 1   00d00633 0000001c 1
7ff00313 0000001e 0   00341413 00000022 1   00812703 00000024 1
00008067 00000026 1   00100073 00000028 1   00040463 0000002a 1
000017b7 0000002c 1   0020006f 0000002e 1   00000000 00000030 1
00000000 00000032 1   00000000 00000034 1   00000000 00000036 1
00112623 00000038 0   00000013 0000003c 1
